/* rtl/rv32i_types_pkg.sv */
// Scalar word types
`default_nettype none

package rv32i_types_pkg;

    // width of one architectural register word
    localparam int WORD_W = 32;

    // one data word as held in a scalar or vector element slot
    typedef logic [WORD_W-1:0] word_t;

    // full product of two words, twice the word width
    typedef logic [2*WORD_W-1:0] dword_t;

endpackage

`default_nettype wire

/* rtl/rv32v_types_pkg.sv */
// Vector lane multiply types
`default_nettype none

package rv32v_types_pkg;

    // element width of the current vector instruction
    typedef enum logic [1:0] {
        SEW8  = 2'b00,  // byte elements
        SEW16 = 2'b01,  // halfword elements
        SEW32 = 2'b10   // word elements, no widening from here
    } sew_t;

    // which result the lane builds from the product
    typedef enum logic [2:0] {
        VMUL_MUL   = 3'd0,  // plain product slice
        VMUL_MACC  = 3'd1,  // vd plus product
        VMUL_NMSAC = 3'd2,  // vd minus product
        VMUL_MADD  = 3'd3,  // vd is the multiplicand and vs2 is added
        VMUL_NMSUB = 3'd4   // vd is the multiplicand and the product is taken from vs2
    } vmulop_t;

    // control word shared by every lane
    typedef struct packed {
        logic    vmul_en;        // held high by the issuer until completion
        vmulop_t vmulop;         // result operation
        sew_t    vsew;           // element width
        logic    sign;           // both operands signed when set
        logic    vmul_ret_high;  // return the high half of the product
        logic    vmul_widen;     // return a 2*SEW result
    } vmul_ctrl_t;

    // per-lane element operands
    typedef struct packed {
        rv32i_types_pkg::word_t vs1_data;  // always the multiplier
        rv32i_types_pkg::word_t vs2_data;  // multiplicand or addend
        rv32i_types_pkg::word_t vd_data;   // accumulator or multiplicand
    } vmul_operands_t;

    // everything one lane needs for one instruction
    typedef struct packed {
        vmul_ctrl_t     ctrl;
        vmul_operands_t ops;
    } vmul_input_t;

    // lane result and back-pressure level
    typedef struct packed {
        logic                   vmul_busy;  // inputs are ignored while high
        rv32i_types_pkg::word_t vd_res;     // valid in the completion cycle only
    } vmul_output_t;

endpackage

`default_nettype wire

/* rtl/pp_mul32.sv */
// Iterative partial-product multiplier
`default_nettype none
`timescale 1ns/1ps

module pp_mul32 #(
    parameter int MUL_STEP_BITS = 4  // multiplier bits retired per cycle, one of 1, 2, 4 or 8
) (
    input  logic                    CLK,
    input  logic                    nRST,
    input  rv32i_types_pkg::word_t  multiplicand,
    input  rv32i_types_pkg::word_t  multiplier,
    input  logic                    is_signed,
    input  logic                    start,
    output logic                    finished,
    output rv32i_types_pkg::dword_t product
);

    localparam int STEPS = 32 / MUL_STEP_BITS;  // cycles spent in RUN
    localparam int CNT_W = $clog2(STEPS);       // enough to count down from STEPS-1

    typedef logic [CNT_W-1:0] step_cnt_t;

    // sequencer states
    typedef enum logic [1:0] {
        IDLE = 2'b00,  // waiting for start
        RUN  = 2'b01,  // adding partial products
        DONE = 2'b10   // product ready, finished is high for this one cycle
    } state_t;

    state_t                  state;       // sequencer state
    step_cnt_t               count;       // steps left after the current one
    rv32i_types_pkg::word_t  mcand_mag;   // magnitude of the incoming multiplicand
    rv32i_types_pkg::word_t  mplier_mag;  // magnitude of the incoming multiplier
    logic                    load;        // accept a new pair this cycle
    logic                    last_step;   // final accumulation happens this cycle
    rv32i_types_pkg::dword_t mcand_q;     // multiplicand shifted up by the bits already retired
    rv32i_types_pkg::word_t  mplier_q;    // multiplier bits not yet retired sit at the bottom
    rv32i_types_pkg::dword_t acc_q;       // running unsigned sum
    rv32i_types_pkg::dword_t acc_next;    // sum after this cycle's partial products
    logic                    negate_q;    // result sign differs from the magnitude sum
    rv32i_types_pkg::dword_t product_q;   // held until the next multiply completes

    // two's complement of the most negative word is itself, which reads as 2^31 unsigned
    assign mcand_mag  = (is_signed && multiplicand[31]) ? -multiplicand : multiplicand;
    assign mplier_mag = (is_signed && multiplier[31])   ? -multiplier   : multiplier;

    assign load      = start && (state != RUN);    // a start during RUN is ignored
    assign last_step = (state == RUN) && (count == '0);

    // sequencer and step counter
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= IDLE;
            count <= '0;
        end else begin
            case (state)
                IDLE, DONE: begin
                    if (start) begin
                        state <= RUN;                     // operands are captured on this edge
                        count <= step_cnt_t'(STEPS - 1);  // STEPS accumulation edges follow
                    end else begin
                        state <= IDLE;
                    end
                end
                RUN: begin
                    if (count == '0) begin
                        state <= DONE;                    // product lands on this same edge
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // add one partial product for every low multiplier bit in this slice
    always_comb begin
        acc_next = acc_q;
        for (int i = 0; i < MUL_STEP_BITS; i++) begin
            if (mplier_q[i]) begin
                acc_next = acc_next + (mcand_q << i);
            end
        end
    end

    // datapath registers
    always_ff @(posedge CLK) begin
        if (load) begin
            mcand_q  <= {32'b0, mcand_mag};
            mplier_q <= mplier_mag;
            acc_q    <= '0;
            negate_q <= is_signed && (multiplicand[31] ^ multiplier[31]);
        end else if (state == RUN) begin
            mcand_q  <= mcand_q << MUL_STEP_BITS;   // next slice weighs MUL_STEP_BITS more
            mplier_q <= mplier_q >> MUL_STEP_BITS;  // retire the bits just used
            acc_q    <= acc_next;
        end
        if (last_step) begin
            product_q <= negate_q ? -acc_next : acc_next;  // sign fix applied once at the end
        end
    end

    assign finished = (state == DONE);  // DONE always leaves after one cycle
    assign product  = product_q;

endmodule

`default_nettype wire

/* rtl/rv32v_multiplier.sv */
// Vector lane multiplier
`default_nettype none
`timescale 1ns/1ps

module rv32v_multiplier #(
    parameter int MUL_STEP_BITS = 4  // passed straight down to pp_mul32
) (
    input  logic                          CLK,
    input  logic                          nRST,
    input  rv32v_types_pkg::vmul_input_t  vmul_in,
    output rv32v_types_pkg::vmul_output_t vmul_out
);

    rv32i_types_pkg::word_t  mcand_raw;     // multiplicand before extension
    rv32i_types_pkg::word_t  mcand_ext;     // multiplicand narrowed to SEW and extended
    rv32i_types_pkg::word_t  mplier_ext;    // multiplier narrowed to SEW and extended
    rv32i_types_pkg::dword_t full_product;  // held product of the extended operands
    rv32i_types_pkg::word_t  product;       // slice chosen for this instruction
    logic                    start;         // one-cycle launch into pp_mul32
    logic                    busy;          // a multiply is in flight
    logic                    finished;      // pp_mul32 completion pulse

    // keep the low SEW bits and fill the rest from the sign bit or with zeros
    function automatic rv32i_types_pkg::word_t extend(
        input rv32i_types_pkg::word_t x,
        input rv32v_types_pkg::sew_t  sew,
        input logic                   sgn
    );
        rv32i_types_pkg::word_t y;
        case (sew)
            rv32v_types_pkg::SEW8:  y = {{24{sgn & x[7]}}, x[7:0]};
            rv32v_types_pkg::SEW16: y = {{16{sgn & x[15]}}, x[15:0]};
            default:                y = x;  // SEW32 uses the whole word
        endcase
        return y;
    endfunction

    // madd and nmsub multiply by the destination instead of vs2
    assign mcand_raw = ((vmul_in.ctrl.vmulop == rv32v_types_pkg::VMUL_MADD) ||
                        (vmul_in.ctrl.vmulop == rv32v_types_pkg::VMUL_NMSUB))
                       ? vmul_in.ops.vd_data : vmul_in.ops.vs2_data;

    assign mcand_ext  = extend(mcand_raw, vmul_in.ctrl.vsew, vmul_in.ctrl.sign);
    assign mplier_ext = extend(vmul_in.ops.vs1_data, vmul_in.ctrl.vsew, vmul_in.ctrl.sign);

    assign start = vmul_in.ctrl.vmul_en & ~busy;  // only an idle lane accepts work

    pp_mul32 #(
        .MUL_STEP_BITS(MUL_STEP_BITS)
    ) pp_mul32_inst (
        .CLK          (CLK),
        .nRST         (nRST),
        .multiplicand (mcand_ext),
        .multiplier   (mplier_ext),
        .is_signed    (vmul_in.ctrl.sign),
        .start        (start),
        .finished     (finished),
        .product      (full_product)
    );

    // busy is set on the issue edge and cleared on the edge after finished
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
        end else if (finished) begin
            busy <= 1'b0;
        end
    end

    // busy level covers the issue cycle too, so it drops exactly in the completion cycle
    assign vmul_out.vmul_busy = start | (busy & ~finished);

    // pick the product slice for the element width, zero extended to a word
    always_comb begin
        case (vmul_in.ctrl.vsew)
            rv32v_types_pkg::SEW8:
                product = vmul_in.ctrl.vmul_ret_high ? {24'b0, full_product[15:8]} :
                          vmul_in.ctrl.vmul_widen    ? {16'b0, full_product[15:0]} :
                                                       {24'b0, full_product[7:0]};
            rv32v_types_pkg::SEW16:
                product = vmul_in.ctrl.vmul_ret_high ? {16'b0, full_product[31:16]} :
                          vmul_in.ctrl.vmul_widen    ? full_product[31:0] :
                                                       {16'b0, full_product[15:0]};
            default:
                product = vmul_in.ctrl.vmul_ret_high ? full_product[63:32]
                                                     : full_product[31:0];  // widen has no meaning at SEW32
        endcase
    end

    // apply the accumulate form, all sums wrap at 32 bits
    always_comb begin
        case (vmul_in.ctrl.vmulop)
            rv32v_types_pkg::VMUL_MACC:  vmul_out.vd_res = vmul_in.ops.vd_data + product;
            rv32v_types_pkg::VMUL_NMSAC: vmul_out.vd_res = vmul_in.ops.vd_data - product;
            rv32v_types_pkg::VMUL_MADD:  vmul_out.vd_res = vmul_in.ops.vs2_data + product;
            rv32v_types_pkg::VMUL_NMSUB: vmul_out.vd_res = vmul_in.ops.vs2_data - product;
            default:                     vmul_out.vd_res = product;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/rv32v_mul_unit.sv */
// Vector multiply unit top
`default_nettype none
`timescale 1ns/1ps

module rv32v_mul_unit #(
    parameter int NUM_LANES     = 4,  // lanes working side by side
    parameter int MUL_STEP_BITS = 4   // multiplier bits retired per cycle in every lane
) (
    input  logic                                           CLK,
    input  logic                                           nRST,
    input  rv32v_types_pkg::vmul_ctrl_t                    ctrl,
    input  rv32v_types_pkg::vmul_operands_t [NUM_LANES-1:0] ops,
    output rv32v_types_pkg::vmul_output_t   [NUM_LANES-1:0] res
);

    // per-lane input word, control copied into each one
    rv32v_types_pkg::vmul_input_t [NUM_LANES-1:0] lane_in;

    // all lanes see the same enable and fields, so they start and finish together
    for (genvar lane = 0; lane < NUM_LANES; lane++) begin : g_lane

        assign lane_in[lane].ctrl = ctrl;        // one control word for the whole unit
        assign lane_in[lane].ops  = ops[lane];   // each lane has its own elements

        rv32v_multiplier #(
            .MUL_STEP_BITS(MUL_STEP_BITS)
        ) rv32v_multiplier_inst (
            .CLK      (CLK),
            .nRST     (nRST),
            .vmul_in  (lane_in[lane]),
            .vmul_out (res[lane])  // busy and result go straight out, no extra stage
        );

    end

endmodule

`default_nettype wire

/* bench/rv32v_multiplier_properties.sv */
// Lane handshake assertions
`default_nettype none
`timescale 1ns/1ps

module rv32v_multiplier_properties (
    input logic                          CLK,
    input logic                          nRST,
    input rv32v_types_pkg::vmul_input_t  vmul_in,
    input rv32v_types_pkg::vmul_output_t vmul_out,
    input logic                          start,
    input logic                          busy,
    input logic                          finished,
    input logic                          mul_load   // pp_mul32 accepts a new pair this cycle
);

    // the multiplier leaves DONE after a single cycle
    finished_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        finished |=> !finished)
        else $error("finished held high for more than one cycle");

    // pp_mul32 drops a start that arrives mid-run, so the lane must only start an idle multiplier
    start_when_idle: assert property (@(posedge CLK) disable iff (!nRST)
        start |-> mul_load)
        else $error("start raised while the multiplier was still running");

    // nothing is in flight during reset or right after it
    idle_after_reset: assert property (@(posedge CLK)
        (!nRST || $rose(nRST)) |-> !vmul_out.vmul_busy)
        else $error("vmul_busy high during or right after reset");

    // the issuer holds the elements for the whole multiply
    ops_held: assert property (@(posedge CLK) disable iff (!nRST)
        (vmul_in.ctrl.vmul_en && busy) |-> $stable(vmul_in.ops))
        else $error("operands changed while the lane was busy");

endmodule

bind rv32v_multiplier rv32v_multiplier_properties rv32v_multiplier_properties_inst (
    .CLK      (CLK),
    .nRST     (nRST),
    .vmul_in  (vmul_in),
    .vmul_out (vmul_out),
    .start    (start),
    .busy     (busy),
    .finished (finished),
    .mul_load (pp_mul32_inst.load)
);

`default_nettype wire

/* bench/tb_rv32v_mul_unit.sv */
// Vector multiply unit testbench
`default_nettype none
`timescale 1ns/1ps

module tb_rv32v_mul_unit;

    localparam int NUM_LANES     = 4;
    localparam int MUL_STEP_BITS = 4;
    localparam int STEPS         = 32 / MUL_STEP_BITS;  // accumulate cycles per multiply
    localparam int DONE_CYCLE    = STEPS + 2;  // issue cycle, then STEPS+1 cycles from the start edge
    localparam int CLK_PERIOD    = 8;
    localparam int RESET_CYCLES  = 4;
    localparam int WAIT_LIMIT    = STEPS + 4;           // cycles allowed from issue to completion
    localparam int RAND_OPS      = 40;
    localparam int TOTAL_OPS     = 130;                 // every issue of every test, rounded up
    localparam int WATCHDOG_NS   = (TOTAL_OPS * (STEPS + 4) + RESET_CYCLES + 100) * CLK_PERIOD;
    localparam logic [15:0] SEED = 16'd15951;

    typedef rv32v_types_pkg::vmul_operands_t [NUM_LANES-1:0] lane_ops_t;
    typedef rv32i_types_pkg::word_t [NUM_LANES-1:0]          lane_words_t;

    logic                                          CLK  = 1'b0;
    logic                                          nRST = 1'b0;
    rv32v_types_pkg::vmul_ctrl_t                   ctrl;  // shared by all lanes
    lane_ops_t                                     ops;
    rv32v_types_pkg::vmul_output_t [NUM_LANES-1:0] res;

    logic [15:0] lfsr;              // random source state
    int          total_checks = 0;
    int          total_errors = 0;
    int          test_checks  = 0;  // cleared as each test ends
    int          test_errors  = 0;
    int          tests_run    = 0;

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    rv32v_mul_unit #(
        .NUM_LANES     (NUM_LANES),
        .MUL_STEP_BITS (MUL_STEP_BITS)
    ) rv32v_mul_unit_inst (
        .CLK  (CLK),
        .nRST (nRST),
        .ctrl (ctrl),
        .ops  (ops),
        .res  (res)
    );

    // x^16 + x^14 + x^13 + x^11 + 1, shifting toward the top
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one lfsr step per bit, newest bit lands at the bottom
    task automatic rand_bits(input int n, output rv32i_types_pkg::word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic fill_random(output lane_ops_t o);
        rv32i_types_pkg::word_t r;
        for (int l = 0; l < NUM_LANES; l++) begin
            rand_bits(32, r);
            o[l].vs1_data = r;
            rand_bits(32, r);
            o[l].vs2_data = r;
            rand_bits(32, r);
            o[l].vd_data = r;
        end
    endtask

    function automatic int sew_bits(input rv32v_types_pkg::sew_t s);
        case (s)
            rv32v_types_pkg::SEW8:  return 8;
            rv32v_types_pkg::SEW16: return 16;
            default:                return 32;
        endcase
    endfunction

    // element moved to the top of 64 bits, then shifted back down with its fill
    function automatic logic [63:0] extend_elem(input rv32i_types_pkg::word_t x, input int w,
                                                input logic sgn);
        logic [63:0] v;
        v = {32'b0, x} << (64 - w);
        if (sgn) begin
            v = $signed(v) >>> (64 - w);
        end else begin
            v = v >> (64 - w);
        end
        return v;
    endfunction

    // expected vd_res from the element rules of the multiply stage
    function automatic rv32i_types_pkg::word_t model_result(input rv32v_types_pkg::vmul_ctrl_t c,
                                                            input rv32v_types_pkg::vmul_operands_t o);
        int          w;
        logic        vd_mult;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] p;
        logic [63:0] slice;
        w       = sew_bits(c.vsew);
        vd_mult = (c.vmulop == rv32v_types_pkg::VMUL_MADD) ||
                  (c.vmulop == rv32v_types_pkg::VMUL_NMSUB);
        a = extend_elem(vd_mult ? o.vd_data : o.vs2_data, w, c.sign);
        b = extend_elem(o.vs1_data, w, c.sign);
        p = a * b;  // both sign extended to 64 bits so the low 64 bits are exact
        if (c.vmul_ret_high) begin
            slice = (p >> w) & ((64'd1 << w) - 64'd1);
        end else if (c.vmul_widen && w < 32) begin
            slice = p & ((64'd1 << (2 * w)) - 64'd1);
        end else begin
            slice = p & ((64'd1 << w) - 64'd1);
        end
        case (c.vmulop)
            rv32v_types_pkg::VMUL_MACC:  return o.vd_data + slice[31:0];
            rv32v_types_pkg::VMUL_NMSAC: return o.vd_data - slice[31:0];
            rv32v_types_pkg::VMUL_MADD:  return o.vs2_data + slice[31:0];
            rv32v_types_pkg::VMUL_NMSUB: return o.vs2_data - slice[31:0];
            default:                     return slice[31:0];
        endcase
    endfunction

    function automatic rv32v_types_pkg::vmul_ctrl_t make_ctrl(input rv32v_types_pkg::vmulop_t op,
                                                              input rv32v_types_pkg::sew_t sew,
                                                              input logic sgn, input logic high,
                                                              input logic wide);
        rv32v_types_pkg::vmul_ctrl_t c;
        c.vmul_en       = 1'b1;  // issue is always a held enable
        c.vmulop        = op;
        c.vsew          = sew;
        c.sign          = sgn;
        c.vmul_ret_high = high;
        c.vmul_widen    = wide;
        return c;
    endfunction

    task automatic check_value(input string what, input rv32i_types_pkg::word_t got,
                               input rv32i_types_pkg::word_t exp);
        total_checks++;
        test_checks++;
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
            total_errors++;
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s finished: %0d checks, %0d errors", name, test_checks, test_errors);
        tests_run++;
        test_checks = 0;
        test_errors = 0;
    endtask

    // issue on a rising edge, then watch busy at falling edges until the completion cycle
    task automatic run_op(input rv32v_types_pkg::vmul_ctrl_t c, input lane_ops_t o,
                          output lane_words_t got, output int lat);
        logic done;
        @(posedge CLK);
        ctrl <= c;
        ops  <= o;
        lat  = 0;
        done = 1'b0;
        while (!done && lat < WAIT_LIMIT) begin
            @(negedge CLK);
            lat++;
            done = 1'b1;
            for (int l = 0; l < NUM_LANES; l++) begin
                if (res[l].vmul_busy) begin
                    done = 1'b0;
                end
            end
        end
        if (!done) begin
            $display("ERROR at %0t ns: lanes still busy %0d cycles after issue", $time, lat);
            total_errors++;
            test_errors++;
        end
        for (int l = 0; l < NUM_LANES; l++) begin
            got[l] = res[l].vd_res;  // valid only in this completion cycle
        end
    endtask

    task automatic drop_en();
        @(posedge CLK);
        ctrl.vmul_en <= 1'b0;  // a held enable would start another multiply
    endtask

    task automatic compare_lanes(input string what, input rv32v_types_pkg::vmul_ctrl_t c,
                                 input lane_ops_t o, input lane_words_t got);
        for (int l = 0; l < NUM_LANES; l++) begin
            check_value($sformatf("%s lane %0d", what, l), got[l], model_result(c, o[l]));
        end
    endtask

    task automatic exec_and_check(input string what, input rv32v_types_pkg::vmul_ctrl_t c,
                                  input lane_ops_t o);
        lane_words_t got;
        int          lat;
        run_op(c, o, got, lat);
        drop_en();
        compare_lanes(what, c, o, got);
    endtask

    // same operands in every lane against a hand-worked value
    task automatic known_answer(input string what, input rv32v_types_pkg::vmul_ctrl_t c,
                                input rv32i_types_pkg::word_t vs1, input rv32i_types_pkg::word_t vs2,
                                input rv32i_types_pkg::word_t vd, input rv32i_types_pkg::word_t exp);
        lane_ops_t   o;
        lane_words_t got;
        int          lat;
        for (int l = 0; l < NUM_LANES; l++) begin
            o[l].vs1_data = vs1;
            o[l].vs2_data = vs2;
            o[l].vd_data  = vd;
        end
        run_op(c, o, got, lat);
        drop_en();
        for (int l = 0; l < NUM_LANES; l++) begin
            check_value($sformatf("%s lane %0d", what, l), got[l], exp);
        end
    endtask

    task automatic check_idle(input string what);
        @(negedge CLK);
        for (int l = 0; l < NUM_LANES; l++) begin
            check_value($sformatf("%s lane %0d busy", what, l), 32'(res[l].vmul_busy), 32'd0);
        end
    endtask

    task automatic busy_protocol();
        lane_ops_t                   o;
        lane_words_t                 got;
        int                          lat;
        rv32v_types_pkg::vmul_ctrl_t c [3];
        c[0] = make_ctrl(rv32v_types_pkg::VMUL_MUL, rv32v_types_pkg::SEW32, 1'b1, 1'b0, 1'b0);
        c[1] = make_ctrl(rv32v_types_pkg::VMUL_MACC, rv32v_types_pkg::SEW16, 1'b0, 1'b0, 1'b1);
        c[2] = make_ctrl(rv32v_types_pkg::VMUL_NMSUB, rv32v_types_pkg::SEW8, 1'b1, 1'b1, 1'b0);
        check_idle("after reset");
        fill_random(o);
        run_op(c[0], o, got, lat);
        check_value("single op latency", 32'(lat), 32'(DONE_CYCLE));  // busy held through the run
        compare_lanes("single op", c[0], o, got);
        drop_en();
        check_idle("after completion");
        check_idle("still after completion");  // no second start from the dropped enable
        for (int n = 0; n < 3; n++) begin
            fill_random(o);
            run_op(c[n], o, got, lat);  // issue edge is the one right after completion
            check_value($sformatf("back-to-back %0d latency", n), 32'(lat), 32'(DONE_CYCLE));
            compare_lanes($sformatf("back-to-back %0d", n), c[n], o, got);
        end
        drop_en();
        end_test("busy_protocol");
    endtask

    task automatic sew32_products();
        rv32i_types_pkg::word_t vals [7] = '{32'h8000_0000, 32'hFFFF_FFFF, 32'h7FFF_FFFF,
                                             32'h0000_0001, 32'h0000_0000, 32'h1234_5678,
                                             32'h9ABC_DEF0};
        lane_ops_t o;
        for (int s = 0; s < 2; s++) begin
            for (int h = 0; h < 2; h++) begin
                for (int k = 0; k < 7; k++) begin
                    for (int l = 0; l < NUM_LANES; l++) begin
                        o[l].vs1_data = vals[(k + l) % 7];          // lanes see different pairs
                        o[l].vs2_data = vals[(k + 2 * l + 3) % 7];
                        o[l].vd_data  = 32'h5A5A_5A5A;              // ignored by a plain multiply
                    end
                    exec_and_check($sformatf("sew32 s%0d h%0d k%0d", s, h, k),
                                   make_ctrl(rv32v_types_pkg::VMUL_MUL, rv32v_types_pkg::SEW32,
                                             s[0], h[0], 1'b0), o);
                end
            end
        end
        known_answer("signed min*min high",
                     make_ctrl(rv32v_types_pkg::VMUL_MUL, rv32v_types_pkg::SEW32, 1'b1, 1'b1, 1'b0),
                     32'h8000_0000, 32'h8000_0000, 32'h0, 32'h4000_0000);
        known_answer("unsigned ones*ones high",
                     make_ctrl(rv32v_types_pkg::VMUL_MUL, rv32v_types_pkg::SEW32, 1'b0, 1'b1, 1'b0),
                     32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0, 32'hFFFF_FFFE);
        end_test("sew32_products");
    endtask

    task automatic narrow_elements();
        lane_ops_t             o;
        rv32v_types_pkg::sew_t sew;
        for (int w = 0; w < 2; w++) begin
            sew = w[0] ? rv32v_types_pkg::SEW16 : rv32v_types_pkg::SEW8;
            for (int s = 0; s < 2; s++) begin
                for (int m = 0; m < 3; m++) begin  // low, high, widen
                    for (int r = 0; r < 2; r++) begin
                        fill_random(o);  // bits above the element are garbage
                        if (r == 0) begin
                            o[0].vs1_data = w[0] ? 32'hA5A5_8000 : 32'hA5A5_A580;
                            o[0].vs2_data = w[0] ? 32'h5A5A_FFFF : 32'h5A5A_5AFF;
                        end
                        exec_and_check($sformatf("sew%0d s%0d m%0d r%0d", w[0] ? 16 : 8, s, m, r),
                                       make_ctrl(rv32v_types_pkg::VMUL_MUL, sew, s[0], m == 1,
                                                 m == 2), o);
                    end
                end
            end
        end
        known_answer("sew8 signed min*min widen",
                     make_ctrl(rv32v_types_pkg::VMUL_MUL, rv32v_types_pkg::SEW8, 1'b1, 1'b0, 1'b1),
                     32'hA5A5_A580, 32'h5A5A_5A80, 32'h0, 32'h0000_4000);
        known_answer("sew16 unsigned ones*ones high",
                     make_ctrl(rv32v_types_pkg::VMUL_MUL, rv32v_types_pkg::SEW16, 1'b0, 1'b1, 1'b0),
                     32'h1234_FFFF, 32'h9876_FFFF, 32'h0, 32'h0000_FFFE);
        end_test("narrow_elements");
    endtask

    task automatic accumulate_forms();
        lane_ops_t                o;
        rv32v_types_pkg::vmulop_t op;
        rv32v_types_pkg::sew_t    sew;
        for (int k = 1; k < 5; k++) begin
            op = rv32v_types_pkg::vmulop_t'(3'(k));
            for (int w = 0; w < 3; w++) begin
                sew = rv32v_types_pkg::sew_t'(2'(w));
                for (int s = 0; s < 2; s++) begin
                    fill_random(o);
                    o[0].vs1_data = 32'hFFFF_FFFF;  // lane 0 drives the sums past 32 bits
                    o[0].vs2_data = 32'h8000_0001;
                    o[0].vd_data  = 32'hFFFF_FFFF;
                    exec_and_check($sformatf("%s sew%0d s%0d", op.name(), sew_bits(sew), s),
                                   make_ctrl(op, sew, s[0], 1'b0, 1'b0), o);
                end
            end
        end
        // 5*3+100 shows vd is the multiplicand, vs2*3+5 would give 305
        known_answer("madd uses vd",
                     make_ctrl(rv32v_types_pkg::VMUL_MADD, rv32v_types_pkg::SEW32, 1'b0, 1'b0, 1'b0),
                     32'd3, 32'd100, 32'd5, 32'd115);
        known_answer("nmsub wraps below zero",
                     make_ctrl(rv32v_types_pkg::VMUL_NMSUB, rv32v_types_pkg::SEW32, 1'b0, 1'b0, 1'b0),
                     32'd1, 32'd0, 32'd1, 32'hFFFF_FFFF);
        known_answer("macc wraps past the top",
                     make_ctrl(rv32v_types_pkg::VMUL_MACC, rv32v_types_pkg::SEW32, 1'b0, 1'b0, 1'b0),
                     32'd1, 32'd1, 32'hFFFF_FFFF, 32'd0);
        end_test("accumulate_forms");
    endtask

    task automatic random_lanes();
        lane_ops_t                o;
        rv32i_types_pkg::word_t   r;
        rv32v_types_pkg::vmulop_t op;
        rv32v_types_pkg::sew_t    sew;
        for (int n = 0; n < RAND_OPS; n++) begin
            rand_bits(3, r);
            op = rv32v_types_pkg::vmulop_t'(3'(r % 5));
            rand_bits(2, r);
            sew = rv32v_types_pkg::sew_t'(2'(r % 3));
            rand_bits(3, r);  // sign, high, widen
            fill_random(o);
            exec_and_check($sformatf("random %0d", n),
                           make_ctrl(op, sew, r[0], r[1], r[2] & ~r[1]), o);
        end
        end_test("random_lanes");
    endtask

    // ends a run that stalls somewhere in the tests
    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run still going after %0d ns", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        ctrl = '0;
        ops  = '0;
        lfsr = SEED;
        repeat (RESET_CYCLES) @(posedge CLK);
        nRST <= 1'b1;
        busy_protocol();  // first, so the idle check sees the lanes straight out of reset
        sew32_products();
        narrow_elements();
        accumulate_forms();
        random_lanes();
        repeat (2) @(posedge CLK);
        $display("%0d tests, %0d checks, %0d errors", tests_run, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
rtl/rv32i_types_pkg.sv
rtl/rv32v_types_pkg.sv
rtl/pp_mul32.sv
rtl/rv32v_multiplier.sv
rtl/rv32v_mul_unit.sv
bench/rv32v_multiplier_properties.sv
bench/tb_rv32v_mul_unit.sv

/* run_sim.sh */
#!/bin/sh
# build and run the vector multiply testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_rv32v_mul_unit
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --top-module "$TOP" -Mdir "$OBJ_DIR" -f tb.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$OBJ_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$LOG"; then
    echo "testbench reported failure, see $LOG"
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi

echo "simulation passed"
exit 0
